// ==== design/rv32_pkg.sv ====
package rv32_pkg;

    ////////////////////////////////////////////////////////////
    // Data width
    ////////////////////////////////////////////////////////////

    localparam int xlen = 32;

    ////////////////////////////////////////////////////////////
    // ALU controls
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        alu_add_sub = 3'b000,
        alu_xor     = 3'b001,
        alu_or      = 3'b010,
        alu_and     = 3'b011,
        alu_sll     = 3'b100,
        alu_srl_sra = 3'b101,
        alu_slt     = 3'b110,
        alu_sltu    = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        src1_reg  = 2'b00,
        src1_pc   = 2'b01,
        src1_zero = 2'b10      // 2'b11 is unused
    } src1_t;

    typedef enum logic [1:0] {
        src2_reg  = 2'b00,
        src2_imm  = 2'b01,
        src2_zero = 2'b10,
        src2_four = 2'b11
    } src2_t;

    ////////////////////////////////////////////////////////////
    // Major opcodes handled by the execute path
    ////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_t;

endpackage

// ==== design/rv32_ctrl_if.sv ====
interface rv32_ctrl_if import rv32_pkg::*;;
    alu_op_t         op;
    logic            sub_sra;    // Subtract, or arithmetic right shift
    src1_t           src1;
    src2_t           src2;
    logic [xlen-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            rd_write;

    modport decoder (
        output op, sub_sra, src1, src2, imm,
        output rs1, rs2, rd, rd_write
    );

    modport alu (input op, sub_sra, src1, src2, imm);

    modport regs (input rs1, rs2, rd, rd_write);
endinterface

// ==== design/rv32_decoder.sv ====
module rv32_decoder import rv32_pkg::*; #(
    parameter int num_regs = 32
) (
    input  logic            instr_valid,
    input  logic [xlen-1:0] instr,
    rv32_ctrl_if.decoder    ctrl
);
    localparam int         addr_w    = $clog2(num_regs);
    localparam logic [4:0] addr_mask = 5'((1 << addr_w) - 1);

    opcode_t         opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic [4:0]      rd_raw;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic            slt_kind;
    logic            supported;

    // funct3 order differs from the ALU group order
    function automatic alu_op_t group_of(input logic [2:0] f3);
        case (f3)
            3'b000:  return alu_add_sub;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alu_srl_sra;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////

    assign opcode    = opcode_t'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rd_raw    = instr[11:7];
    assign slt_kind  = (funct3[2:1] == 2'b01);    // slt and sltu compare via subtract

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    assign ctrl.rs1 = instr[19:15] & addr_mask;   // RV32E sees only the low registers
    assign ctrl.rs2 = instr[24:20] & addr_mask;
    assign ctrl.rd  = rd_raw & addr_mask;

    ////////////////////////////////////////////////////////////
    // Source and operation selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl.op      = group_of(funct3);
        ctrl.sub_sra = 1'b0;
        ctrl.src1    = src1_reg;
        ctrl.src2    = src2_reg;
        ctrl.imm     = imm_i;
        supported    = 1'b1;

        case (opcode)
            opc_op: begin
                ctrl.sub_sra = slt_kind ||
                               (funct7_b5 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            opc_op_imm: begin
                ctrl.src2    = src2_imm;
                ctrl.sub_sra = slt_kind || (funct7_b5 && funct3 == 3'b101);  // No subi
            end
            opc_lui: begin
                ctrl.op   = alu_add_sub;
                ctrl.src1 = src1_zero;
                ctrl.src2 = src2_imm;
                ctrl.imm  = imm_u;
            end
            opc_auipc: begin
                ctrl.op   = alu_add_sub;
                ctrl.src1 = src1_pc;
                ctrl.src2 = src2_imm;
                ctrl.imm  = imm_u;
            end
            opc_jal, opc_jalr: begin
                ctrl.op   = alu_add_sub;                 // Link value only
                ctrl.src1 = src1_pc;
                ctrl.src2 = src2_four;
            end
            default: supported = 1'b0;
        endcase
    end

    assign ctrl.rd_write = instr_valid && supported && (rd_raw != 5'd0) &&
                           (int'(rd_raw) < num_regs);
endmodule

// ==== design/rv32_regs.sv ====
module rv32_regs import rv32_pkg::*; #(
    parameter int num_regs = 32
) (
    input  logic            clk,
    input  logic            reset,
    rv32_ctrl_if.regs       ctrl,
    input  logic [xlen-1:0] result,
    output logic [xlen-1:0] rs1_value,
    output logic [xlen-1:0] rs2_value,
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_value
);
    localparam int addr_w = $clog2(num_regs);

    logic [xlen-1:0]   regs_q [num_regs];
    logic [addr_w-1:0] rs1_addr;
    logic [addr_w-1:0] rs2_addr;
    logic [addr_w-1:0] rd_addr;

    assign rs1_addr = ctrl.rs1[addr_w-1:0];
    assign rs2_addr = ctrl.rs2[addr_w-1:0];
    assign rd_addr  = ctrl.rd[addr_w-1:0];

    assign rs1_value = (rs1_addr == '0) ? '0 : regs_q[rs1_addr];   // x0 is hardwired
    assign rs2_value = (rs2_addr == '0) ? '0 : regs_q[rs2_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs_q[i] <= '0;
            end
        end else if (ctrl.rd_write) begin
            regs_q[rd_addr] <= result;
        end
    end

    ////////////////////////////////////////////////////////////
    // Writeback stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ctrl.rd_write;    // One pulse per write
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.rd_write) begin
            wb_rd    <= ctrl.rd;
            wb_value <= result;
        end
    end

    assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_rd != 5'd0)
        else $error("writeback reported for x0");

    // Decoder masking must keep every address inside the file
    assert property (@(posedge clk) disable iff (reset)
        int'(ctrl.rs1) < num_regs && int'(ctrl.rs2) < num_regs &&
        (!ctrl.rd_write || int'(ctrl.rd) < num_regs))
        else $error("register address beyond num_regs");
endmodule

// ==== design/rv32_alu.sv ====
module rv32_alu import rv32_pkg::*; (
    rv32_ctrl_if.alu        ctrl,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_value,
    input  logic [xlen-1:0] rs2_value,
    output logic [xlen-1:0] result
);
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [4:0]      shamt;
    logic [xlen:0]   add_sub;     // Top bit is carry out, or borrow on subtract
    logic [xlen:0]   shift_ext;
    logic            src1_neg;
    logic            src2_neg;
    logic            res_neg;
    logic            ovf;
    logic            lt;
    logic            ltu;

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.src1)
            src1_reg:  src1 = rs1_value;
            src1_pc:   src1 = pc;
            src1_zero: src1 = '0;
            default:   src1 = '0;
        endcase

        case (ctrl.src2)
            src2_reg:  src2 = rs2_value;
            src2_imm:  src2 = ctrl.imm;
            src2_zero: src2 = '0;
            default:   src2 = xlen'(4);   // src2_four
        endcase
    end

    assign shamt    = src2[4:0];          // Only the low 5 bits count
    assign src1_neg = src1[xlen-1];
    assign src2_neg = src2[xlen-1];

    ////////////////////////////////////////////////////////////
    // Adder, shifter and comparison flags
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (ctrl.sub_sra) begin
            add_sub = {1'b0, src1} - {1'b0, src2};
        end else begin
            add_sub = {1'b0, src1} + {1'b0, src2};
        end
    end

    assign shift_ext = $signed({ctrl.sub_sra & src1_neg, src1}) >>> shamt;  // Fill bit on top

    assign res_neg = add_sub[xlen-1];
    assign ovf     = (src1_neg != src2_neg) && (res_neg != src1_neg);   // Subtract overflow

    assign lt  = res_neg ^ ovf;
    assign ltu = add_sub[xlen];

    always_comb begin
        case (ctrl.op)
            alu_add_sub: result = add_sub[xlen-1:0];
            alu_xor:     result = src1 ^ src2;
            alu_or:      result = src1 | src2;
            alu_and:     result = src1 & src2;
            alu_sll:     result = src1 << shamt;
            alu_srl_sra: result = shift_ext[xlen-1:0];
            alu_slt:     result = {{(xlen-1){1'b0}}, lt};
            default:     result = {{(xlen-1){1'b0}}, ltu};
        endcase
    end
endmodule

// ==== design/rv32_exec.sv ====
module rv32_exec import rv32_pkg::*; #(
    parameter int num_regs = 32           // 32 for RV32I, 16 for RV32E
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            instr_valid,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_value
);
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic [xlen-1:0] result;

    rv32_ctrl_if ctrl ();

    ////////////////////////////////////////////////////////////
    // Decode, register file and ALU
    ////////////////////////////////////////////////////////////

    rv32_decoder #(
        .num_regs    (num_regs)
    ) rv32_decoder_i (
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl        (ctrl.decoder)
    );

    rv32_regs #(
        .num_regs  (num_regs)
    ) rv32_regs_i (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl.regs),
        .result    (result),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_value  (wb_value)
    );

    rv32_alu rv32_alu_i (
        .ctrl      (ctrl.alu),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .result    (result)
    );
endmodule

// ==== verif/rv32_exec_vectors.svh ====
`ifndef RV32_EXEC_VECTORS_SVH
`define RV32_EXEC_VECTORS_SVH

// Columns: test name, instr, pc, writeback expected, wb_rd, wb_value
// Entries run in order, so later entries read registers set by earlier ones

task automatic load_vectors();
    // Constants through LUI and ADDI
    add_vector("lui_x1",        32'h123450B7, 32'h0000_0000, 1'b1, 5'd1,  32'h1234_5000);
    add_vector("addi_neg_x2",   32'hFFB00113, 32'h0000_0000, 1'b1, 5'd2,  32'hFFFF_FFFB);
    add_vector("addi_x3",       32'h67808193, 32'h0000_0000, 1'b1, 5'd3,  32'h1234_5678);
    add_vector("lui_x4",        32'h80000237, 32'h0000_0000, 1'b1, 5'd4,  32'h8000_0000);
    add_vector("addi_x5",       32'h0F020293, 32'h0000_0000, 1'b1, 5'd5,  32'h8000_00F0);
    // Register arithmetic and logic
    add_vector("add_wrap",      32'h00218333, 32'h0000_0000, 1'b1, 5'd6,  32'h1234_5673);
    add_vector("sub",           32'h403103B3, 32'h0000_0000, 1'b1, 5'd7,  32'hEDCB_A983);
    add_vector("xor",           32'h0011C433, 32'h0000_0000, 1'b1, 5'd8,  32'h0000_0678);
    add_vector("or",            32'h0032E4B3, 32'h0000_0000, 1'b1, 5'd9,  32'h9234_56F8);
    add_vector("and",           32'h0053F533, 32'h0000_0000, 1'b1, 5'd10, 32'h8000_0080);
    // Shift amount 36, only the low 5 bits (4) count
    add_vector("addi_shamt",    32'h02400593, 32'h0000_0000, 1'b1, 5'd11, 32'h0000_0024);
    add_vector("sll",           32'h00B29633, 32'h0000_0000, 1'b1, 5'd12, 32'h0000_0F00);
    add_vector("srl_neg",       32'h00B2D6B3, 32'h0000_0000, 1'b1, 5'd13, 32'h0800_000F);
    add_vector("sra_neg",       32'h40B2D733, 32'h0000_0000, 1'b1, 5'd14, 32'hF800_000F);
    add_vector("srli_neg",      32'h0082D793, 32'h0000_0000, 1'b1, 5'd15, 32'h0080_0000);
    add_vector("srai_neg",      32'h4082D813, 32'h0000_0000, 1'b1, 5'd16, 32'hFF80_0000);
    // Mixed-sign compares
    add_vector("slt_neg_pos",   32'h003128B3, 32'h0000_0000, 1'b1, 5'd17, 32'h0000_0001);
    add_vector("sltu_neg_pos",  32'h00313933, 32'h0000_0000, 1'b1, 5'd18, 32'h0000_0000);
    add_vector("sltu_pos_neg",  32'h0021B9B3, 32'h0000_0000, 1'b1, 5'd19, 32'h0000_0001);
    // PC-relative results
    add_vector("auipc_wrap",    32'hFFFFFA17, 32'h0000_2000, 1'b1, 5'd20, 32'h0000_1000);
    add_vector("auipc",         32'h00010A97, 32'h0000_1000, 1'b1, 5'd21, 32'h0001_1000);
    add_vector("jal_link",      32'h00800B6F, 32'h0000_0400, 1'b1, 5'd22, 32'h0000_0404);
    add_vector("jalr_link",     32'h00008BE7, 32'hFFFF_FFFC, 1'b1, 5'd23, 32'h0000_0000);
    // No write for x0 or an unsupported opcode
    add_vector("addi_x0",       32'h00518013, 32'h0000_0000, 1'b0, 5'd0,  32'h0000_0000);
    add_vector("lw_unsupported", 32'h0000AC03, 32'h0000_0000, 1'b0, 5'd0, 32'h0000_0000);
    add_vector("or_x0_x0",      32'h00006CB3, 32'h0000_0000, 1'b1, 5'd25, 32'h0000_0000);
    add_vector("add_x24_x0",    32'h000C0D33, 32'h0000_0000, 1'b1, 5'd26, 32'h0000_0000);
endtask

`endif

// ==== verif/rv32_exec_tb.sv ====
module rv32_exec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 8;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_value;

    string       vec_name  [$];
    logic [31:0] vec_instr [$];
    logic [31:0] vec_pc    [$];
    logic        vec_wb    [$];
    logic [4:0]  vec_rd    [$];
    logic [31:0] vec_value [$];
    logic        loaded;

    rv32_exec #(
        .num_regs    (32)
    ) rv32_exec_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value)
    );

    ////////////////////////////////////////////////////////////
    // Vector table
    ////////////////////////////////////////////////////////////

    task automatic add_vector(input string name, input logic [31:0] word,
                              input logic [31:0] pc_value, input logic wb_exp,
                              input logic [4:0] rd_exp, input logic [31:0] value_exp);
        vec_name.push_back(name);
        vec_instr.push_back(word);
        vec_pc.push_back(pc_value);
        vec_wb.push_back(wb_exp);
        vec_rd.push_back(rd_exp);
        vec_value.push_back(value_exp);
    endtask

    `include "rv32_exec_vectors.svh"

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("** Error: test %s, %s expected 0x%08h, actual 0x%08h",
                 name, field, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // Sampled on the falling edge, half a cycle after the writeback register
    task automatic check_writeback(input int idx);
        assert (wb_valid === vec_wb[idx])
            else report_mismatch(vec_name[idx], "wb_valid", 32'(vec_wb[idx]), 32'(wb_valid));
        if (vec_wb[idx]) begin
            assert (wb_rd === vec_rd[idx])
                else report_mismatch(vec_name[idx], "wb_rd", 32'(vec_rd[idx]), 32'(wb_rd));
            assert (wb_value === vec_value[idx])
                else report_mismatch(vec_name[idx], "wb_value", vec_value[idx], wb_value);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, stimulus and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        loaded      = 1'b0;
        load_vectors();
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (wb_valid === 1'b0)
            else report_mismatch("idle_after_reset", "wb_valid", 32'd0, 32'(wb_valid));

        for (int i = 0; i < vec_name.size(); i++) begin
            instr_valid = 1'b1;
            instr       = vec_instr[i];
            pc          = vec_pc[i];
            @(negedge clk);
            check_writeback(i);
            instr_valid = 1'b0;
            instr       = '0;
            pc          = '0;
            @(negedge clk);
            assert (wb_valid === 1'b0)     // Single-cycle pulse
                else report_mismatch(vec_name[i], "wb_valid after pulse", 32'd0,
                                     32'(wb_valid));
        end

        $display("NO ERRORS");
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        repeat (vec_name.size() * 2 + 20) @(posedge clk);
        $display("Timeout: the vector loop did not finish within %0d cycles",
                 vec_name.size() * 2 + 20);
        $display("ERRORS FOUND");
        $fatal(1);
    end
endmodule

// ==== tb.f ====
+incdir+verif
design/rv32_pkg.sv
design/rv32_ctrl_if.sv
design/rv32_decoder.sv
design/rv32_regs.sv
design/rv32_alu.sv
design/rv32_exec.sv
verif/rv32_exec_tb.sv

// ==== Makefile ====
# Verilator build and run for the RV32 execute path

TOP       ?= rv32_exec_tb
FLIST     ?= tb.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
TIMESCALE ?= 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: TOP FLIST LOG BUILD_DIR VERILATOR TIMESCALE"

test:
	$(VERILATOR) --binary --assert --timescale $(TIMESCALE) \
		-f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
